// ==== hw/switch_pkg.sv ====
`default_nettype none

package switch_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int data_width  = 48;                 // header needs more than 32 bits
    localparam int port_num    = 4;
    localparam int port_width  = $clog2(port_num);
    localparam int pri_width   = 3;
    localparam int count_width = 8;                  // payload words per frame
    localparam int crc_width   = 32;

    // whatever is left of the word above the header fields
    localparam int pad_width = data_width - count_width - crc_width - pri_width;

    //////////////////////////////////////////////////////////////////////
    // header and data word
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [pad_width-1:0]   pad;    // zero
        logic [count_width-1:0] count;  // payload word count
        logic [crc_width-1:0]   crc;    // expected crc of the payload
        logic [pri_width-1:0]   pri;    // low bits
    } hdr_t;

    // header during poll, payload during send
    typedef union packed {
        hdr_t                  hdr;
        logic [data_width-1:0] word;
    } word_u;

    //////////////////////////////////////////////////////////////////////
    // arbiter result
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;  // one cycle
        logic [port_width-1:0] port;
    } grant_t;

endpackage

`default_nettype wire

// ==== hw/port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_arbiter #(
    parameter int PORT_NUM = switch_pkg::port_num
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      select_scheme, // 1 = round-robin
    input  logic                                      arb_req,
    input  logic [PORT_NUM-1:0]                       pending,
    input  logic [PORT_NUM*switch_pkg::pri_width-1:0] priorities,
    output switch_pkg::grant_t                        grant
);

    localparam int PW = switch_pkg::pri_width;

    logic [switch_pkg::port_width-1:0] last_ptr;  // last granted port
    logic                              fix_hit;
    logic [switch_pkg::port_width-1:0] fix_idx;
    logic [PW-1:0]                     fix_pri;
    logic                              rr_hit;
    logic [switch_pkg::port_width-1:0] rr_idx;

    //////////////////////////////////////////////////////////////////////
    // fixed priority
    //////////////////////////////////////////////////////////////////////

    // strict compare so the lower index keeps a tie
    always_comb begin
        fix_hit = 1'b0;
        fix_idx = '0;
        fix_pri = '0;
        for (int i = 0; i < PORT_NUM; i++) begin
            if (pending[i] && (!fix_hit || priorities[i*PW +: PW] > fix_pri)) begin
                fix_hit = 1'b1;
                fix_idx = switch_pkg::port_width'(i);
                fix_pri = priorities[i*PW +: PW];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // round-robin
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        int cand;
        rr_hit = 1'b0;
        rr_idx = last_ptr;
        for (int k = 1; k <= PORT_NUM; k++) begin
            cand = (int'(last_ptr) + k) % PORT_NUM;  // walk on from last grant
            if (!rr_hit && pending[cand]) begin
                rr_hit = 1'b1;
                rr_idx = switch_pkg::port_width'(cand);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // grant register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant    <= '0;
            last_ptr <= switch_pkg::port_width'(PORT_NUM - 1);  // port 0 goes first
        end else begin
            grant.valid <= 1'b0;
            if (arb_req) begin
                if (select_scheme) begin
                    grant.valid <= rr_hit;
                    grant.port  <= rr_idx;
                    if (rr_hit) last_ptr <= rr_idx;
                end else begin
                    grant.valid <= fix_hit;
                    grant.port  <= fix_idx;
                    if (fix_hit) last_ptr <= fix_idx;  // keep rotation in step
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/crc32_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc32_check #(
    parameter int DATA_WIDTH = switch_pkg::data_width
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [DATA_WIDTH-1:0]           pay_word,
    input  logic                            pay_vld,
    input  logic                            pay_first,
    input  logic                            pay_last,
    input  logic [switch_pkg::crc_width-1:0] exp_crc,
    output logic                            crc_err
);

    localparam int CW = switch_pkg::crc_width;
    localparam logic [CW-1:0] POLY = 32'h04C1_1DB7;

    logic [CW-1:0] crc_q;     // running value
    logic [CW-1:0] crc_seed;
    logic [CW-1:0] crc_next;

    // one word, msb first, no reflection
    function automatic logic [CW-1:0] crc_word(
        input logic [CW-1:0] crc_in,
        input logic [CW-1:0] data
    );
        logic [CW-1:0] c;
        logic          fb;
        c = crc_in;
        for (int i = CW - 1; i >= 0; i--) begin
            fb = c[CW-1] ^ data[i];
            c  = {c[CW-2:0], 1'b0};
            if (fb) c = c ^ POLY;
        end
        return c;
    endfunction

    assign crc_seed = pay_first ? '1 : crc_q;  // restart at frame start
    assign crc_next = crc_word(crc_seed, pay_word[CW-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q   <= '1;
            crc_err <= 1'b0;
        end else begin
            crc_err <= 1'b0;  // only pulses with eop
            if (pay_vld) begin
                crc_q <= crc_next;
                if (pay_last) crc_err <= (crc_next != exp_crc);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/sel_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module sel_control #(
    parameter int PORT_NUM   = switch_pkg::port_num,
    parameter int DATA_WIDTH = switch_pkg::data_width
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  switch_pkg::word_u                         data_in,
    input  logic [PORT_NUM-1:0]                       empty,
    input  logic                                      ready,
    input  switch_pkg::grant_t                        grant,
    output logic [PORT_NUM-1:0]                       pending,
    output logic [PORT_NUM*switch_pkg::pri_width-1:0] priorities,
    output logic                                      arb_req,
    output logic [switch_pkg::port_width-1:0]         rd_sel,
    output logic                                      rd_en,
    output logic [DATA_WIDTH-1:0]                     rd_data,
    output logic                                      rd_vld,
    output logic                                      rd_sop,
    output logic                                      rd_eop,
    output logic [DATA_WIDTH-1:0]                     pay_word,
    output logic                                      pay_vld,
    output logic                                      pay_first,
    output logic                                      pay_last,
    output logic [switch_pkg::crc_width-1:0]          exp_crc
);

    localparam int PW = switch_pkg::pri_width;

    localparam logic [1:0] ST_SCAN = 2'd0;
    localparam logic [1:0] ST_ARB  = 2'd1;
    localparam logic [1:0] ST_SEND = 2'd2;

    localparam logic [switch_pkg::port_width-1:0] LAST_PORT =
        switch_pkg::port_width'(PORT_NUM - 1);

    logic [1:0]                         state;
    logic [switch_pkg::port_width-1:0]  scan_ptr;    // port visited in this pass
    logic                               hdr_wait;    // header due on data_in
    logic                               found;       // new header seen this pass
    logic [switch_pkg::port_width-1:0]  gnt_port;
    logic [switch_pkg::count_width-1:0] issue_left;  // reads still to issue
    logic [switch_pkg::count_width-1:0] recv_left;   // words still to arrive
    logic                               first_word;
    logic                               rd_d1;       // payload read one cycle ago

    logic [switch_pkg::crc_width-1:0]   crc_tab [PORT_NUM];
    logic [switch_pkg::count_width-1:0] cnt_tab [PORT_NUM];

    logic eligible;
    logic poll_rd;
    logic scan_step;
    logic send_rd;

    //////////////////////////////////////////////////////////////////////
    // read strobes to the queues
    //////////////////////////////////////////////////////////////////////

    // a port gets polled once per frame, until it is sent
    assign eligible  = !pending[scan_ptr] && !empty[scan_ptr];
    assign poll_rd   = (state == ST_SCAN) && !hdr_wait && eligible && ready;
    assign scan_step = (state == ST_SCAN) && (hdr_wait || !eligible);

    // empty pauses the frame, it picks up again when data is back
    assign send_rd = (state == ST_SEND) && ready && !empty[gnt_port] && (issue_left != '0);

    assign rd_en  = poll_rd || send_rd;
    assign rd_sel = (state == ST_SEND) ? gnt_port : scan_ptr;

    //////////////////////////////////////////////////////////////////////
    // payload toward the crc checker
    //////////////////////////////////////////////////////////////////////

    assign pay_word  = data_in.word;
    assign pay_vld   = rd_d1;
    assign pay_first = rd_d1 && first_word;
    assign pay_last  = rd_d1 && (recv_left == switch_pkg::count_width'(1));
    assign exp_crc   = crc_tab[gnt_port];

    //////////////////////////////////////////////////////////////////////
    // header table
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_SCAN && hdr_wait) begin
            priorities[scan_ptr*PW +: PW] <= data_in.hdr.pri;
            crc_tab[scan_ptr]             <= data_in.hdr.crc;
            cnt_tab[scan_ptr]             <= data_in.hdr.count;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // scan / arbitrate / send
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_SCAN;
            scan_ptr   <= '0;
            hdr_wait   <= 1'b0;
            found      <= 1'b0;
            pending    <= '0;
            arb_req    <= 1'b0;
            gnt_port   <= '0;
            issue_left <= '0;
            recv_left  <= '0;
            first_word <= 1'b0;
            rd_d1      <= 1'b0;
        end else begin
            arb_req <= 1'b0;  // single pulse
            rd_d1   <= send_rd;
            case (state)
                ST_SCAN: begin
                    if (poll_rd) hdr_wait <= 1'b1;
                    if (scan_step) begin
                        hdr_wait <= 1'b0;
                        if (hdr_wait) pending[scan_ptr] <= 1'b1;  // header captured
                        if (scan_ptr == LAST_PORT) begin
                            scan_ptr <= '0;
                            found    <= 1'b0;
                            // quiet pass, time to pick a frame
                            if (!found && !hdr_wait && (|pending)) begin
                                arb_req <= 1'b1;
                                state   <= ST_ARB;
                            end
                        end else begin
                            scan_ptr <= scan_ptr + 1'b1;
                            if (hdr_wait) found <= 1'b1;
                        end
                    end
                end

                ST_ARB: begin
                    // grant shows up the cycle after the request
                    if (!arb_req) begin
                        if (!grant.valid) begin
                            state <= ST_SCAN;
                        end else if (cnt_tab[grant.port] == '0) begin
                            pending[grant.port] <= 1'b0;  // nothing to send
                            state               <= ST_SCAN;
                        end else begin
                            gnt_port   <= grant.port;
                            issue_left <= cnt_tab[grant.port];
                            recv_left  <= cnt_tab[grant.port];
                            first_word <= 1'b1;
                            state      <= ST_SEND;
                        end
                    end
                end

                ST_SEND: begin
                    if (send_rd) issue_left <= issue_left - 1'b1;
                    if (pay_vld) begin
                        recv_left  <= recv_left - 1'b1;
                        first_word <= 1'b0;
                    end
                    if (pay_last) begin
                        pending[gnt_port] <= 1'b0;  // entry free again
                        state             <= ST_SCAN;
                    end
                end

                default: state <= ST_SCAN;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output stream
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            rd_vld <= pay_vld;
            rd_sop <= pay_first;
            rd_eop <= pay_last;  // lines up with crc_err
        end
    end

    always_ff @(posedge clk) begin
        if (pay_vld) rd_data <= pay_word;
    end

endmodule

`default_nettype wire

// ==== hw/out_port_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module out_port_top #(
    parameter int PORT_NUM   = switch_pkg::port_num,
    parameter int DATA_WIDTH = switch_pkg::data_width
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  switch_pkg::word_u                 data_in,
    input  logic [PORT_NUM-1:0]               empty,
    input  logic                              ready,
    input  logic                              select_scheme,
    output logic [switch_pkg::port_width-1:0] rd_sel,
    output logic                              rd_en,
    output logic [DATA_WIDTH-1:0]             rd_data,
    output logic                              rd_vld,
    output logic                              rd_sop,
    output logic                              rd_eop,
    output logic                              crc_err
);

    // arbiter handshake
    logic [PORT_NUM-1:0]                       pending;
    logic [PORT_NUM*switch_pkg::pri_width-1:0] priorities;
    logic                                      arb_req;
    switch_pkg::grant_t                        grant;

    // payload tap for the checker
    logic [DATA_WIDTH-1:0]            pay_word;
    logic                             pay_vld;
    logic                             pay_first;
    logic                             pay_last;
    logic [switch_pkg::crc_width-1:0] exp_crc;

    port_arbiter #(
        .PORT_NUM (PORT_NUM)
    ) u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .select_scheme (select_scheme),
        .arb_req       (arb_req),
        .pending       (pending),
        .priorities    (priorities),
        .grant         (grant)
    );

    crc32_check #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_crc (
        .clk       (clk),
        .rst_n     (rst_n),
        .pay_word  (pay_word),
        .pay_vld   (pay_vld),
        .pay_first (pay_first),
        .pay_last  (pay_last),
        .exp_crc   (exp_crc),
        .crc_err   (crc_err)
    );

    sel_control #(
        .PORT_NUM   (PORT_NUM),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_sel (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (data_in),
        .empty      (empty),
        .ready      (ready),
        .grant      (grant),
        .pending    (pending),
        .priorities (priorities),
        .arb_req    (arb_req),
        .rd_sel     (rd_sel),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .rd_vld     (rd_vld),
        .rd_sop     (rd_sop),
        .rd_eop     (rd_eop),
        .pay_word   (pay_word),
        .pay_vld    (pay_vld),
        .pay_first  (pay_first),
        .pay_last   (pay_last),
        .exp_crc    (exp_crc)
    );

endmodule

`default_nettype wire

// ==== bench/tb_out_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_out_port;

    localparam int DW    = switch_pkg::data_width;
    localparam int NP    = switch_pkg::port_num;
    localparam int QD    = 256;  // words per queue model over the whole run
    localparam int MAX_T = 8;
    localparam int MAX_F = 64;
    localparam int MAX_W = 512;

    logic                              clk;
    logic                              rst_n;
    switch_pkg::word_u                 data_in;
    logic [NP-1:0]                     empty;
    logic                              ready;
    logic                              select_scheme;
    logic [switch_pkg::port_width-1:0] rd_sel;
    logic                              rd_en;
    logic [DW-1:0]                     rd_data;
    logic                              rd_vld;
    logic                              rd_sop;
    logic                              rd_eop;
    logic                              crc_err;

    // file contents
    int            t_num;
    int            t_scheme [MAX_T];
    int            t_f_lo [MAX_T];
    int            t_f_hi [MAX_T];
    int            t_e_lo [MAX_T];
    int            t_e_hi [MAX_T];
    int            f_num;
    int            f_port [MAX_F];
    int            f_pri [MAX_F];
    int            f_cnt [MAX_F];
    int            f_w_lo [MAX_F];
    logic [31:0]   f_crc [MAX_F];
    int            w_num;
    logic [DW-1:0] w_mem [MAX_W];
    int            e_num;
    int            e_port [MAX_F];
    int            e_err [MAX_F];

    // queue models
    logic [DW-1:0]                     q_mem [NP][QD];
    logic                              q_hdr [NP][QD];
    int                                q_wr [NP];
    int                                q_rd [NP];
    logic                              rd_seen;
    logic [switch_pkg::port_width-1:0] sel_seen;
    logic [1:0]                        pay_rd_d;  // payload reads of the last two cycles

    // expected output beats of the running test
    logic [DW-1:0] x_word [MAX_W];
    logic          x_sop [MAX_W];
    logic          x_eop [MAX_W];
    logic          x_err [MAX_W];
    int            beat_total;
    int            beat_idx;

    int seed = 32'h9a144892;
    int err_cnt;
    int test_pass;
    int test_fail;
    int wd_limit;

    out_port_top u_out_port_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_in       (data_in),
        .empty         (empty),
        .ready         (ready),
        .select_scheme (select_scheme),
        .rd_sel        (rd_sel),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .rd_vld        (rd_vld),
        .rd_sop        (rd_sop),
        .rd_eop        (rd_eop),
        .crc_err       (crc_err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                              input logic got_sop, input logic exp_sop,
                              input logic got_eop, input logic exp_eop);
        if (got !== exp || got_sop !== exp_sop || got_eop !== exp_eop) begin
            $display("FAILED %0t: word %h sop %b eop %b, expected %h sop %b eop %b",
                     $time, got, got_sop, got_eop, exp, exp_sop, exp_eop);
            err_cnt++;
        end
    endtask

    task automatic check_err(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %0t: crc_err %b at eop, expected %b", $time, got, exp);
            err_cnt++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // queue models answer a read on the next cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        rd_seen  = rd_en;
        sel_seen = rd_sel;
        if (rst_n) begin
            if (rd_en && (!ready || empty[rd_sel])) begin
                $display("FAILED %0t: rd_en to port %0d with ready low or empty high",
                         $time, rd_sel);
                err_cnt++;
            end
            if (rd_vld !== pay_rd_d[1]) begin
                $display("FAILED %0t: rd_vld %b, expected %b two cycles after the read",
                         $time, rd_vld, pay_rd_d[1]);
                err_cnt++;
            end
        end
        pay_rd_d = {pay_rd_d[0], rst_n && rd_en && (q_rd[rd_sel] != q_wr[rd_sel])
                                 && !q_hdr[rd_sel][q_rd[rd_sel]]};
    end

    always @(posedge clk) begin
        #1;
        if (rst_n && rd_seen) begin
            if (q_rd[sel_seen] == q_wr[sel_seen]) begin
                $display("DUT read port %0d while its queue was empty", sel_seen);
                err_cnt++;
            end else begin
                data_in.word = q_mem[sel_seen][q_rd[sel_seen]];
                q_rd[sel_seen]++;
            end
        end
        ready = ($random(seed) & 7) != 0;
        for (int p = 0; p < NP; p++) begin
            if (q_rd[p] == q_wr[p])
                empty[p] = 1'b1;
            else if (!q_hdr[p][q_rd[p]] && ($random(seed) & 7) == 0)
                empty[p] = 1'b1;  // stall inside a frame only
            else
                empty[p] = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            if (rd_vld && beat_idx < beat_total) begin
                check_word(rd_data, x_word[beat_idx], rd_sop, x_sop[beat_idx],
                           rd_eop, x_eop[beat_idx]);
                if (x_eop[beat_idx]) check_err(crc_err, x_err[beat_idx]);
                beat_idx++;
            end else if (rd_vld) begin
                $display("FAILED %0t: extra word %h on the stream", $time, rd_data);
                err_cnt++;
            end else if (rd_sop || rd_eop) begin
                $display("FAILED %0t: frame marker without rd_vld", $time);
                err_cnt++;
            end
            if (crc_err && !rd_eop) begin
                $display("FAILED %0t: crc_err high away from eop", $time);
                err_cnt++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test data
    //////////////////////////////////////////////////////////////////////

    task automatic read_testdata();
        int              fd;
        int              code;
        int              n;
        int              port;
        int              pri;
        int              cnt;
        logic [8*16-1:0] tok;
        logic [8*128-1:0] rest;
        logic [31:0]     crc;
        logic [DW-1:0]   w;
        fd = $fopen("bench/out_port_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/out_port_testdata.txt");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "test") begin
                    code = $fscanf(fd, "%d", n);
                    t_scheme[t_num] = n;
                    t_f_lo[t_num]   = f_num;
                    t_e_lo[t_num]   = e_num;
                end else if (tok == "frame") begin
                    code = $fscanf(fd, "%d %d %d %h", port, pri, cnt, crc);
                    f_port[f_num] = port;
                    f_pri[f_num]  = pri;
                    f_cnt[f_num]  = cnt;
                    f_crc[f_num]  = crc;
                    f_w_lo[f_num] = w_num;
                    for (int i = 0; i < cnt; i++) begin
                        code = $fscanf(fd, "%h", w);
                        w_mem[w_num] = w;
                        w_num++;
                    end
                    f_num++;
                end else if (tok == "expect") begin
                    code = $fscanf(fd, "%d %d", port, n);
                    e_port[e_num] = port;
                    e_err[e_num]  = n;
                    e_num++;
                end else if (tok == "end") begin
                    t_f_hi[t_num] = f_num;
                    t_e_hi[t_num] = e_num;
                    t_num++;
                end
            end
            $fclose(fd);
        end
    endtask

    // header word first and the payload after it
    task automatic load_frame(input int f);
        switch_pkg::word_u h;
        int                p;
        p           = f_port[f];
        h.hdr.pad   = '0;
        h.hdr.count = f_cnt[f][switch_pkg::count_width-1:0];
        h.hdr.crc   = f_crc[f];
        h.hdr.pri   = f_pri[f][switch_pkg::pri_width-1:0];
        q_mem[p][q_wr[p]] = h.word;
        q_hdr[p][q_wr[p]] = 1'b1;
        q_wr[p]++;
        for (int k = 0; k < f_cnt[f]; k++) begin
            q_mem[p][q_wr[p]] = w_mem[f_w_lo[f] + k];
            q_hdr[p][q_wr[p]] = 1'b0;
            q_wr[p]++;
        end
    endtask

    task automatic run_test(input int t);
        int nxt [NP];
        int b;
        int fi;
        int port;
        int errs_before;
        errs_before = err_cnt;
        for (int p = 0; p < NP; p++) nxt[p] = t_f_lo[t];
        b = 0;
        // expected port order picks each port's frames in file order
        for (int e = t_e_lo[t]; e < t_e_hi[t]; e++) begin
            port = e_port[e];
            fi   = -1;
            for (int f = nxt[port]; f < t_f_hi[t] && fi < 0; f++)
                if (f_port[f] == port) fi = f;
            if (fi < 0) begin
                $display("test %0d expects a frame from port %0d that is not queued", t, port);
                err_cnt++;
            end else begin
                nxt[port] = fi + 1;
                for (int k = 0; k < f_cnt[fi]; k++) begin
                    x_word[b] = w_mem[f_w_lo[fi] + k];
                    x_sop[b]  = (k == 0);
                    x_eop[b]  = (k == f_cnt[fi] - 1);
                    x_err[b]  = e_err[e][0];
                    b++;
                end
            end
        end
        @(posedge clk);
        #2;
        beat_idx      = 0;
        beat_total    = b;
        select_scheme = t_scheme[t][0];
        for (int f = t_f_lo[t]; f < t_f_hi[t]; f++) load_frame(f);
        wait (beat_idx >= beat_total);
        repeat (20) @(posedge clk);  // catch trailing words
        for (int p = 0; p < NP; p++) begin
            if (q_rd[p] != q_wr[p]) begin
                $display("port %0d queue still holds %0d words", p, q_wr[p] - q_rd[p]);
                err_cnt++;
            end
        end
        if (err_cnt == errs_before) test_pass++;
        else test_fail++;
        $display("test %0d scheme %0d frames %0d: %s", t, t_scheme[t],
                 t_e_hi[t] - t_e_lo[t], (err_cnt == errs_before) ? "pass" : "fail");
    endtask

    //////////////////////////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        wait (wd_limit > 0);
        repeat (wd_limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, output stream stalled", wd_limit);
        $display("TB FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int errs_before;
        rst_n         = 1'b0;
        data_in       = '0;
        empty         = '1;
        ready         = 1'b0;
        select_scheme = 1'b0;
        rd_seen       = 1'b0;
        sel_seen      = '0;
        pay_rd_d      = '0;
        beat_total    = 0;
        beat_idx      = 0;
        err_cnt       = 0;
        test_pass     = 0;
        test_fail     = 0;
        wd_limit      = 0;
        t_num         = 0;
        f_num         = 0;
        w_num         = 0;
        e_num         = 0;
        for (int p = 0; p < NP; p++) begin
            q_wr[p] = 0;
            q_rd[p] = 0;
        end
        read_testdata();
        if (t_num == 0) begin
            $display("no tests found in the data file");
            err_cnt++;
        end
        wd_limit = 20 * w_num + 2000;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        // quiet after reset while every queue is empty
        errs_before = err_cnt;
        repeat (10) begin
            @(negedge clk);
            if (rd_en || rd_vld || rd_sop || rd_eop || crc_err) begin
                $display("FAILED %0t: output active with all queues empty", $time);
                err_cnt++;
            end
        end
        if (err_cnt == errs_before) test_pass++;
        else test_fail++;
        $display("reset idle check: %s", (err_cnt == errs_before) ? "pass" : "fail");

        for (int t = 0; t < t_num; t++) run_test(t);

        $display("tests passed %0d, failed %0d, errors %0d", test_pass, test_fail, err_cnt);
        if (test_fail == 0 && err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/out_port_testdata.txt ====
# test <scheme 0=fixed 1=round-robin> ... end
# frame <port> <pri> <count> <crc hex> <payload words hex>, expect <port> <crc_err>
test 0
frame 0 2 3 00000000 1000ffffffff 100100000000 100200000000
frame 1 5 2 04c11db7 1100ffffffff 110100000001
frame 2 5 1 04c11db7 1200fffffffe
frame 3 7 4 04c11db7 1300ffffffff 130100000000 130200000000 130300000001
expect 3 0
expect 1 0
expect 2 0
expect 0 0
end
# rotation continues after port 0
test 1
frame 0 7 1 04c11db7 2000fffffffe
frame 0 7 2 00000000 2010ffffffff 201100000000
frame 1 1 2 04c11db7 2100ffffffff 210100000001
frame 1 1 1 04c11db7 2110fffffffe
frame 2 6 1 04c11db7 2200fffffffe
frame 2 6 3 00000000 2210ffffffff 221100000000 221200000000
frame 3 0 2 00000000 2300ffffffff 230100000000
frame 3 0 1 04c11db7 2310fffffffe
expect 1 0
expect 2 0
expect 3 0
expect 0 0
expect 1 0
expect 2 0
expect 3 0
expect 0 0
end
# port 2 carries a corrupted crc
test 0
frame 0 1 2 00000000 3000ffffffff 300100000000
frame 1 3 6 04c11db7 3100ffffffff 310100000000 310200000000 310300000000 310400000000 310500000001
frame 2 4 2 0000beef 3200ffffffff 320100000000
expect 2 1
expect 1 0
expect 0 0
end

// ==== list.f ====
hw/switch_pkg.sv
hw/port_arbiter.sv
hw/crc32_check.sv
hw/sel_control.sv
hw/out_port_top.sv
bench/tb_out_port.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_out_port -f list.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "TB PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
